// ==== src/soc_cfg_pkg.sv ====
`default_nettype none

package soc_cfg_pkg;

   // native bus word
   localparam int DATA_W = 32;

   // byte addressed memory space, 4 KiB
   localparam int SRAM_ADDR_W = 12;

   // the buses carry word addresses
   localparam int WADDR_W = SRAM_ADDR_W - 2;
   localparam int SRAM_WORDS = 1 << WADDR_W;

   localparam int STRB_W = DATA_W / 8;

   // byte lane select inside a word
   localparam int LANE_W = $clog2(STRB_W);

endpackage

`default_nettype wire

// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   import soc_cfg_pkg::*;

   localparam int NREGS = 16;
   localparam int REG_W = $clog2(NREGS);
   localparam int OPC_W = 4;
   localparam int IMM_W = 16;

   // instruction field positions
   localparam int OP_LSB = 28;
   localparam int RD_LSB = 24;  // rs2 for stores and branches
   localparam int RS1_LSB = 20;
   localparam int RS2_LSB = 16;

   typedef enum logic [OPC_W-1:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LW   = 4'd6,
      OP_SW   = 4'd7,
      OP_SB   = 4'd8,
      OP_BEQ  = 4'd9,
      OP_BNE  = 4'd10,
      OP_HALT = 4'd11
   } opcode_e;

   typedef struct packed {
      opcode_e           op;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] rs1_val;
      logic [DATA_W-1:0] rs2_val;
      logic [DATA_W-1:0] imm;  // sign extended
      logic [DATA_W-1:0] pc;  // word address
   } dec_instr_t;

   typedef struct packed {
      logic              we;
      logic [REG_W-1:0]  rd;
      logic [DATA_W-1:0] result;
      logic [DATA_W-1:0] next_pc;
      logic              halt;
   } exe_result_t;

endpackage

`default_nettype wire

// ==== src/iob_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface iob_bus_if
   import soc_cfg_pkg::*;
();

   logic               avalid;
   logic [WADDR_W-1:0] addr;  // word address
   logic [DATA_W-1:0]  wdata;
   logic [STRB_W-1:0]  wstrb;  // zero means read
   logic [DATA_W-1:0]  rdata;
   logic               rvalid;
   logic               ready;

   modport manager(
      output avalid, addr, wdata, wstrb,
      input  rdata, rvalid, ready
   );

   modport subordinate(
      input  avalid, addr, wdata, wstrb,
      output rdata, rvalid, ready
   );

endinterface

`default_nettype wire

// ==== src/sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram
   import soc_cfg_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   iob_bus_if.subordinate ibus,  // instruction bus, also the boot path
   iob_bus_if.subordinate dbus   // data bus
);

   logic [DATA_W-1:0] mem [SRAM_WORDS];
   logic [DATA_W-1:0] i_rdata_q;
   logic [DATA_W-1:0] d_rdata_q;
   logic              i_rvalid_q;
   logic              d_rvalid_q;
   logic              i_rd;
   logic              d_rd;

   assign i_rd = ibus.avalid & ~(|ibus.wstrb);
   assign d_rd = dbus.avalid & ~(|dbus.wstrb);

   // both buses share one array, dbus wins a same-byte collision
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < STRB_W; b++) begin
         if (ibus.avalid && ibus.wstrb[b]) begin
            mem[ibus.addr][b*8 +: 8] <= ibus.wdata[b*8 +: 8];
         end
         if (dbus.avalid && dbus.wstrb[b]) begin
            mem[dbus.addr][b*8 +: 8] <= dbus.wdata[b*8 +: 8];
         end
      end
      if (i_rd) begin
         i_rdata_q <= mem[ibus.addr];  // old data on a cross-bus write
      end
      if (d_rd) begin
         d_rdata_q <= mem[dbus.addr];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         i_rvalid_q <= 1'b0;
         d_rvalid_q <= 1'b0;
      end else begin
         i_rvalid_q <= i_rd;  // reads only, writes get no response
         d_rvalid_q <= d_rd;
      end
   end

   assign ibus.rdata  = i_rdata_q;
   assign ibus.rvalid = i_rvalid_q;
   assign dbus.rdata  = d_rdata_q;
   assign dbus.rvalid = d_rvalid_q;

   // requests may come back to back
   assign ibus.ready = 1'b1;
   assign dbus.ready = 1'b1;

endmodule

`default_nettype wire

// ==== src/host_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bridge
   import soc_cfg_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               run_req_i,
   output logic               run_ack_o,
   input  logic               host_avalid_i,
   input  logic [WADDR_W-1:0] host_addr_i,
   input  logic [DATA_W-1:0]  host_wdata_i,
   input  logic [STRB_W-1:0]  host_wstrb_i,
   output logic [DATA_W-1:0]  host_rdata_o,
   output logic               host_rvalid_o,
   output logic               core_start_o,
   input  logic               halted_i,
   iob_bus_if.subordinate     core_ibus,
   iob_bus_if.subordinate     core_dbus,
   iob_bus_if.manager         mem_ibus,
   iob_bus_if.manager         mem_dbus
);

   typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_ACK} state_e;

   state_e state_q;
   logic   start_q;
   logic   host_rd_q;  // pending host read on mem_dbus
   logic   host_sel;
   logic   host_ok;
   logic   host_wr;
   logic   host_rd;

   assign host_sel = (state_q == ST_IDLE);
   assign host_ok  = host_sel & ~run_req_i;  // dropped while a run is requested
   assign host_wr  = host_ok & host_avalid_i & (|host_wstrb_i);
   assign host_rd  = host_ok & host_avalid_i & ~(|host_wstrb_i);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         start_q   <= 1'b0;
         host_rd_q <= 1'b0;
      end else begin
         start_q   <= 1'b0;
         host_rd_q <= host_rd;
         case (state_q)
            ST_IDLE: if (run_req_i) begin
               state_q <= ST_RUN;
               start_q <= 1'b1;
            end
            // halted is stale while start is still high
            ST_RUN:  if (halted_i && !start_q) state_q <= ST_ACK;
            ST_ACK:  if (!run_req_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   assign run_ack_o    = (state_q == ST_ACK);
   assign core_start_o = start_q;

   // host writes boot through ibus, host reads go on dbus
   assign mem_ibus.avalid = host_sel ? host_wr : core_ibus.avalid;
   assign mem_ibus.addr   = host_sel ? host_addr_i : core_ibus.addr;
   assign mem_ibus.wdata  = host_sel ? host_wdata_i : core_ibus.wdata;
   assign mem_ibus.wstrb  = host_sel ? host_wstrb_i : core_ibus.wstrb;

   assign mem_dbus.avalid = host_sel ? host_rd : core_dbus.avalid;
   assign mem_dbus.addr   = host_sel ? host_addr_i : core_dbus.addr;
   assign mem_dbus.wdata  = host_sel ? '0 : core_dbus.wdata;
   assign mem_dbus.wstrb  = host_sel ? '0 : core_dbus.wstrb;

   assign core_ibus.rdata  = mem_ibus.rdata;
   assign core_ibus.rvalid = mem_ibus.rvalid;
   assign core_ibus.ready  = mem_ibus.ready;

   assign core_dbus.rdata  = mem_dbus.rdata;
   assign core_dbus.rvalid = mem_dbus.rvalid & ~host_rd_q;
   assign core_dbus.ready  = mem_dbus.ready;

   assign host_rdata_o  = mem_dbus.rdata;
   assign host_rvalid_o = mem_dbus.rvalid & host_rd_q;

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
   import soc_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              start_i,
   input  logic              retire_i,
   input  logic [DATA_W-1:0] next_pc_i,
   iob_bus_if.manager        ibus,
   output logic [REG_W-1:0]  rs1_addr_o,
   output logic [REG_W-1:0]  rs2_addr_o,
   input  logic [DATA_W-1:0] rs1_data_i,
   input  logic [DATA_W-1:0] rs2_data_i,
   output logic              dec_valid_o,
   output dec_instr_t        dec_instr_o
);

   logic [DATA_W-1:0] pc_q;
   logic              fetch_q;
   logic [DATA_W-1:0] instr;
   opcode_e           op;
   logic              rs2_in_rd;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q    <= '0;
         fetch_q <= 1'b0;
      end else begin
         fetch_q <= start_i | retire_i;  // one fetch per start or retire
         if (start_i) begin
            pc_q <= '0;
         end else if (retire_i) begin
            pc_q <= next_pc_i;
         end
      end
   end

   // fetch is a read only
   assign ibus.avalid = fetch_q;
   assign ibus.addr   = pc_q[WADDR_W-1:0];
   assign ibus.wdata  = '0;
   assign ibus.wstrb  = '0;

   assign instr = ibus.rdata;
   assign op    = opcode_e'(instr[OP_LSB +: OPC_W]);

   // stores and branches keep rs2 in the rd field
   assign rs2_in_rd = (op == OP_SW) || (op == OP_SB) || (op == OP_BEQ) || (op == OP_BNE);

   assign rs1_addr_o = instr[RS1_LSB +: REG_W];
   assign rs2_addr_o = rs2_in_rd ? instr[RD_LSB +: REG_W] : instr[RS2_LSB +: REG_W];

   always_comb begin
      dec_instr_o.op      = op;
      dec_instr_o.rd      = instr[RD_LSB +: REG_W];
      dec_instr_o.rs1_val = rs1_data_i;
      dec_instr_o.rs2_val = rs2_data_i;
      dec_instr_o.imm     = {{(DATA_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
      dec_instr_o.pc      = pc_q;
   end

   assign dec_valid_o = ibus.rvalid;  // decode is combinational on rdata

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
   import soc_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       dec_valid_i,
   input  dec_instr_t dec_instr_i,
   iob_bus_if.manager dbus,
   output logic        exe_valid_o,
   output exe_result_t exe_result_o
);

   exe_result_t       res_d;
   exe_result_t       res_q;
   logic              exe_valid_q;
   logic              ld_wait_q;  // LW issued, waiting for rvalid
   logic [DATA_W-1:0] ea;  // rs1 plus immediate
   logic [LANE_W-1:0] lane;
   logic              is_lw;
   logic              is_mem;
   logic              taken;

   assign ea     = dec_instr_i.rs1_val + dec_instr_i.imm;
   assign lane   = ea[LANE_W-1:0];
   assign is_lw  = (dec_instr_i.op == OP_LW);
   assign is_mem = is_lw || (dec_instr_i.op == OP_SW) || (dec_instr_i.op == OP_SB);
   assign taken  = (dec_instr_i.op == OP_BEQ) ?
                   (dec_instr_i.rs1_val == dec_instr_i.rs2_val) :
                   (dec_instr_i.rs1_val != dec_instr_i.rs2_val);

   // data access goes out in the decode cycle
   assign dbus.avalid = dec_valid_i & is_mem;
   assign dbus.addr   = (dec_instr_i.op == OP_SB) ? ea[WADDR_W+LANE_W-1:LANE_W] :
                                                    ea[WADDR_W-1:0];
   assign dbus.wdata  = (dec_instr_i.op == OP_SB) ?
                        DATA_W'(dec_instr_i.rs2_val[7:0]) << {lane, 3'b000} :
                        dec_instr_i.rs2_val;
   assign dbus.wstrb  = (dec_instr_i.op == OP_SW) ? {STRB_W{1'b1}} :
                        (dec_instr_i.op == OP_SB) ? STRB_W'(1) << lane : '0;

   always_comb begin
      res_d         = '0;
      res_d.rd      = dec_instr_i.rd;
      res_d.next_pc = dec_instr_i.pc + 1;
      case (dec_instr_i.op)
         OP_ADD:  res_d.result = dec_instr_i.rs1_val + dec_instr_i.rs2_val;
         OP_SUB:  res_d.result = dec_instr_i.rs1_val - dec_instr_i.rs2_val;
         OP_AND:  res_d.result = dec_instr_i.rs1_val & dec_instr_i.rs2_val;
         OP_OR:   res_d.result = dec_instr_i.rs1_val | dec_instr_i.rs2_val;
         OP_XOR:  res_d.result = dec_instr_i.rs1_val ^ dec_instr_i.rs2_val;
         OP_ADDI: res_d.result = ea;
         OP_SW, OP_SB, OP_LW: ;  // LW data arrives later
         OP_BEQ, OP_BNE: if (taken) res_d.next_pc = dec_instr_i.pc + dec_instr_i.imm;
         default: res_d.halt = 1'b1;  // HALT and unknown codes stop
      endcase
      res_d.we = !res_d.halt && !rs2_field_op(dec_instr_i.op);
   end

   function automatic logic rs2_field_op(opcode_e op);
      return (op == OP_SW) || (op == OP_SB) || (op == OP_BEQ) || (op == OP_BNE);
   endfunction

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         exe_valid_q <= 1'b0;
         ld_wait_q   <= 1'b0;
      end else begin
         exe_valid_q <= (dec_valid_i & ~is_lw) | (ld_wait_q & dbus.rvalid);
         if (dec_valid_i && is_lw) begin
            ld_wait_q <= 1'b1;
         end else if (dbus.rvalid) begin
            ld_wait_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (dec_valid_i) begin
         res_q <= res_d;
      end else if (ld_wait_q && dbus.rvalid) begin
         res_q.result <= dbus.rdata;
      end
   end

   assign exe_valid_o  = exe_valid_q;
   assign exe_result_o = res_q;

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage
   import soc_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              start_i,
   input  logic              exe_valid_i,
   input  exe_result_t       exe_result_i,
   input  logic [REG_W-1:0]  rs1_addr_i,
   input  logic [REG_W-1:0]  rs2_addr_i,
   output logic [DATA_W-1:0] rs1_data_o,
   output logic [DATA_W-1:0] rs2_data_o,
   output logic              retire_o,
   output logic [DATA_W-1:0] next_pc_o,
   output logic              halted_o
);

   logic [DATA_W-1:0] rf [NREGS];
   logic              retire_q;
   logic              halted_q;
   logic [DATA_W-1:0] next_pc_q;

   // r0 is never written
   always_ff @(posedge clk_i) begin
      if (exe_valid_i && exe_result_i.we && (exe_result_i.rd != '0)) begin
         rf[exe_result_i.rd] <= exe_result_i.result;
      end
      if (exe_valid_i) begin
         next_pc_q <= exe_result_i.next_pc;
      end
   end

   assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         retire_q <= 1'b0;
         halted_q <= 1'b0;
      end else begin
         retire_q <= exe_valid_i & ~exe_result_i.halt;
         if (start_i) begin
            halted_q <= 1'b0;  // new run
         end else if (exe_valid_i && exe_result_i.halt) begin
            halted_q <= 1'b1;
         end
      end
   end

   assign retire_o  = retire_q;
   assign next_pc_o = next_pc_q;
   assign halted_o  = halted_q;

endmodule

`default_nettype wire

// ==== src/mini_soc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_soc
   import soc_cfg_pkg::*;
   import isa_pkg::*;
(
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               run_req_i,
   output logic               run_ack_o,
   input  logic               host_avalid_i,
   input  logic [WADDR_W-1:0] host_addr_i,
   input  logic [DATA_W-1:0]  host_wdata_i,
   input  logic [STRB_W-1:0]  host_wstrb_i,
   output logic [DATA_W-1:0]  host_rdata_o,
   output logic               host_rvalid_o
);

   logic              core_start;
   logic              halted;
   logic              dec_valid;
   dec_instr_t        dec_instr;
   logic              exe_valid;
   exe_result_t       exe_result;
   logic              retire;
   logic [DATA_W-1:0] next_pc;
   logic [REG_W-1:0]  rs1_addr;
   logic [REG_W-1:0]  rs2_addr;
   logic [DATA_W-1:0] rs1_data;
   logic [DATA_W-1:0] rs2_data;

   iob_bus_if core_ibus ();
   iob_bus_if core_dbus ();
   iob_bus_if mem_ibus ();
   iob_bus_if mem_dbus ();

   host_bridge u_host_bridge (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .run_req_i    (run_req_i),
      .run_ack_o    (run_ack_o),
      .host_avalid_i(host_avalid_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_wstrb_i (host_wstrb_i),
      .host_rdata_o (host_rdata_o),
      .host_rvalid_o(host_rvalid_o),
      .core_start_o (core_start),
      .halted_i     (halted),
      .core_ibus    (core_ibus.subordinate),
      .core_dbus    (core_dbus.subordinate),
      .mem_ibus     (mem_ibus.manager),
      .mem_dbus     (mem_dbus.manager)
   );

   sram u_sram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .ibus   (mem_ibus.subordinate),
      .dbus   (mem_dbus.subordinate)
   );

   decode_stage u_decode_stage (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (core_start),
      .retire_i   (retire),
      .next_pc_i  (next_pc),
      .ibus       (core_ibus.manager),
      .rs1_addr_o (rs1_addr),
      .rs2_addr_o (rs2_addr),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .dec_valid_o(dec_valid),
      .dec_instr_o(dec_instr)
   );

   execute_stage u_execute_stage (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .dec_valid_i (dec_valid),
      .dec_instr_i (dec_instr),
      .dbus        (core_dbus.manager),
      .exe_valid_o (exe_valid),
      .exe_result_o(exe_result)
   );

   result_stage u_result_stage (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (core_start),
      .exe_valid_i (exe_valid),
      .exe_result_i(exe_result),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rs1_data_o  (rs1_data),
      .rs2_data_o  (rs2_data),
      .retire_o    (retire),
      .next_pc_o   (next_pc),
      .halted_o    (halted)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   // reset released on a rising edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== testbench/mini_soc_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_soc_assert
   import soc_cfg_pkg::*;
(
   input logic              clk_i,
   input logic              rst_n_i,
   input logic              run_req_i,
   input logic              run_ack_o,
   input logic              host_avalid_i,
   input logic [STRB_W-1:0] host_wstrb_i,
   input logic              host_rvalid_o
);

   // host read accepted only while the bridge is idle
   host_rvalid_follows_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      host_rvalid_o |->
         $past(host_avalid_i && (host_wstrb_i == '0) && !run_req_i && !run_ack_o))
      else $error("host_rvalid_o without a host read one cycle earlier");

   ack_held_during_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (run_ack_o && run_req_i) |=> run_ack_o)
      else $error("run_ack_o fell while run_req_i was high");

   ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(run_ack_o) |-> run_req_i)
      else $error("run_ack_o rose without run_req_i");

endmodule

bind mini_soc mini_soc_assert u_mini_soc_assert (.*);

`default_nettype wire

// ==== testbench/mini_soc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mini_soc_tb
   import soc_cfg_pkg::*;
   import isa_pkg::*;
();

   localparam int DATA_BASE = 512;  // memory program area, words 512..639
   localparam int BOOT_BASE = 640;
   localparam int REG_BASE  = 768;
   localparam int MARK_BASE = 896;
   localparam int RUN_LIMIT = 5000;

   logic               clk;
   logic               rst_n;
   logic               run_req;
   logic               run_ack;
   logic               host_avalid;
   logic [WADDR_W-1:0] host_addr;
   logic [DATA_W-1:0]  host_wdata;
   logic [STRB_W-1:0]  host_wstrb;
   logic [DATA_W-1:0]  host_rdata;
   logic               host_rvalid;

   logic [DATA_W-1:0] mem_m [SRAM_WORDS];  // reference memory
   logic [DATA_W-1:0] rf_m [NREGS];  // reference registers
   logic [DATA_W-1:0] prog [$];
   int seed = 88;
   int tests;
   int failed;
   int checks;
   int test_errs;
   int total_errs;

   tb_clock #(.PERIOD_NS(40), .RST_CYCLES(8)) u_tb_clock (.clk_o(clk), .rst_n_o(rst_n));

   mini_soc u_mini_soc (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .run_req_i    (run_req),
      .run_ack_o    (run_ack),
      .host_avalid_i(host_avalid),
      .host_addr_i  (host_addr),
      .host_wdata_i (host_wdata),
      .host_wstrb_i (host_wstrb),
      .host_rdata_o (host_rdata),
      .host_rvalid_o(host_rvalid)
   );

   function automatic int rand_below(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      return $random(seed);
   endfunction

   function automatic logic [DATA_W-1:0] encode(opcode_e op, int rd, int rs1, int rs2, int imm);
      return {op, 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
   endfunction

   // strobed bytes come from d, the rest stay
   function automatic logic [DATA_W-1:0] merge(logic [DATA_W-1:0] old, logic [DATA_W-1:0] d,
                                                logic [STRB_W-1:0] s);
      logic [DATA_W-1:0] m;
      m = {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
      return (old & ~m) | (d & m);
   endfunction

   task automatic check_word(input string what, input int a, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("MISMATCH time %0t: %s word %0d got %08h expected %08h",
                  $time, what, a, got, exp);
         test_errs++;
      end
   endtask

   task automatic check_flag(input string what, input bit got, input bit exp);
      checks++;
      assert (got == exp) else begin
         $display("MISMATCH time %0t: %s is %0b, expected %0b", $time, what, got, exp);
         test_errs++;
      end
   endtask

   task automatic host_write(input int a, input logic [DATA_W-1:0] d,
                             input logic [STRB_W-1:0] s, input bit track);
      @(posedge clk);
      host_avalid <= 1'b1;
      host_addr   <= WADDR_W'(a);
      host_wdata  <= d;
      host_wstrb  <= s;  // never zero here, zero would be a read
      @(posedge clk);
      host_avalid <= 1'b0;
      host_wstrb  <= '0;
      if (track) begin
         mem_m[WADDR_W'(a)] = merge(mem_m[WADDR_W'(a)], d, s);
      end
   endtask

   task automatic host_read(input int a, output logic [DATA_W-1:0] d, output bit got);
      int waited;
      got    = 1'b0;
      d      = '0;
      waited = 0;
      @(posedge clk);
      host_avalid <= 1'b1;
      host_addr   <= WADDR_W'(a);
      host_wstrb  <= '0;
      @(posedge clk);
      host_avalid <= 1'b0;
      while (!got && waited < 3) begin
         @(negedge clk);
         waited++;
         if (host_rvalid) begin
            got = 1'b1;
            d   = host_rdata;
         end
      end
   endtask

   task automatic read_and_check(input string what, input int a, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] d;
      bit                got;
      host_read(a, d, got);
      if (!got) begin
         $display("no host read response for word %0d during %s", a, what);
         test_errs++;
      end else begin
         check_word(what, a, d, exp);
      end
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++) begin
         host_write(i, prog[i], 4'hF, 1'b1);
      end
   endtask

   task automatic init_regs(input int limit);
      for (int k = 1; k < NREGS; k++) begin
         prog.push_back(encode(OP_ADDI, k, 0, 0, rand_below(limit)));
      end
   endtask

   // instruction set interpreter over the reference memory
   task automatic interpret();
      logic [DATA_W-1:0] pc;
      logic [DATA_W-1:0] pc_next;
      logic [DATA_W-1:0] w;
      logic [DATA_W-1:0] imm;
      logic [DATA_W-1:0] a;
      logic [DATA_W-1:0] v1;
      logic [DATA_W-1:0] v2;
      logic [DATA_W-1:0] vs;  // rd field used as a source
      logic [DATA_W-1:0] res;
      logic [REG_W-1:0]  rd;
      opcode_e           op;
      bit                wr;
      bit                done;
      int                steps;
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < RUN_LIMIT) begin
         w       = mem_m[pc[WADDR_W-1:0]];
         op      = opcode_e'(w[31:28]);
         rd      = w[27:24];
         v1      = rf_m[w[23:20]];
         v2      = rf_m[w[19:16]];
         vs      = rf_m[w[27:24]];
         imm     = {{16{w[15]}}, w[15:0]};
         a       = v1 + imm;
         pc_next = pc + 1;
         wr      = 1'b1;
         res     = '0;
         case (op)
            OP_ADD:  res = v1 + v2;
            OP_SUB:  res = v1 - v2;
            OP_AND:  res = v1 & v2;
            OP_OR:   res = v1 | v2;
            OP_XOR:  res = v1 ^ v2;
            OP_ADDI: res = a;
            OP_LW:   res = mem_m[a[WADDR_W-1:0]];
            default: wr = 1'b0;
         endcase
         case (op)
            OP_SW: mem_m[a[WADDR_W-1:0]] = vs;
            OP_SB: mem_m[a[11:2]] = merge(mem_m[a[11:2]], {4{vs[7:0]}}, 4'b0001 << a[1:0]);
            OP_BEQ: if (v1 == vs) pc_next = pc + imm;
            OP_BNE: if (v1 != vs) pc_next = pc + imm;
            OP_HALT: done = 1'b1;
            default: ;
         endcase
         if (wr && rd != '0) rf_m[rd] = res;  // r0 stays zero
         pc = pc_next;
         steps++;
      end
   endtask

   task automatic run_program(input bit probe);
      int                waited;
      logic [DATA_W-1:0] d;
      bit                got;
      if (probe) check_flag("run_ack_o before request", run_ack, 1'b0);
      @(posedge clk);
      run_req <= 1'b1;
      waited = 0;
      while (!run_ack && waited < RUN_LIMIT) begin
         @(negedge clk);
         waited++;
         if (probe && waited == 1) check_flag("run_ack_o in first run cycle", run_ack, 1'b0);
      end
      if (!run_ack) begin
         $display("timeout: run_ack_o did not rise within %0d cycles", RUN_LIMIT);
         test_errs++;
      end
      if (probe) begin
         // bridge is busy, both accesses must be dropped
         host_read(BOOT_BASE, d, got);
         check_flag("host_rvalid_o while run_req_i high", got, 1'b0);
         host_write(BOOT_BASE, ~mem_m[BOOT_BASE], 4'hF, 1'b0);
         check_flag("run_ack_o held while run_req_i high", run_ack, 1'b1);
      end
      @(posedge clk);
      run_req <= 1'b0;
      waited = 0;
      while (run_ack && waited < 4) begin
         @(negedge clk);
         waited++;
      end
      if (run_ack) begin
         $display("timeout: run_ack_o stayed high after run_req_i fell");
         test_errs++;
      end else if (probe) begin
         check_flag("run_ack_o low one cycle after release", waited == 2, 1'b1);
      end
   endtask

   task automatic boot_test();
      int a;
      for (int i = 0; i < 128; i++) host_write(BOOT_BASE + i, rand_word(), 4'hF, 1'b1);
      for (int i = 0; i < 64; i++) begin
         a = BOOT_BASE + rand_below(128);
         host_write(a, rand_word(), 4'(rand_below(15) + 1), 1'b1);  // partial strobes
      end
      for (int i = 0; i < 128; i++) begin
         read_and_check("boot readback", BOOT_BASE + i, mem_m[WADDR_W'(BOOT_BASE + i)]);
      end
   endtask

   task automatic alu_test();
      prog.delete();
      init_regs(65536);
      for (int i = 0; i < 40; i++) begin
         prog.push_back(encode(opcode_e'(4'(rand_below(6))), rand_below(16), rand_below(16),
                               rand_below(16), rand_below(65536)));
      end
      for (int k = 0; k < NREGS; k++) prog.push_back(encode(OP_SW, k, 0, 0, REG_BASE + k));
      prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
      load_program();
      interpret();
      run_program(1'b0);
      for (int k = 0; k < NREGS; k++) begin
         read_and_check($sformatf("register r%0d", k), REG_BASE + k, rf_m[REG_W'(k)]);
      end
   endtask

   task automatic memory_test();
      for (int i = 0; i < 128; i++) host_write(DATA_BASE + i, rand_word(), 4'hF, 1'b1);
      prog.delete();
      init_regs(65536);
      prog.push_back(encode(OP_ADDI, 15, 0, 0, DATA_BASE));  // word base
      prog.push_back(encode(OP_ADDI, 14, 0, 0, DATA_BASE * 4));  // byte base
      for (int i = 0; i < 60; i++) begin
         case (rand_below(3))
            0: prog.push_back(encode(OP_SW, 1 + rand_below(13), 15, 0, rand_below(128)));
            1: prog.push_back(encode(OP_SB, 1 + rand_below(13), 14, 0, rand_below(512)));
            default: prog.push_back(encode(OP_LW, 1 + rand_below(13), 15, 0, rand_below(128)));
         endcase
      end
      prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
      load_program();
      interpret();
      run_program(1'b0);
      for (int i = 0; i < 128; i++) begin
         read_and_check("data area", DATA_BASE + i, mem_m[WADDR_W'(DATA_BASE + i)]);
      end
   endtask

   task automatic branch_test();
      for (int b = 0; b < 12; b++) host_write(MARK_BASE + b, '0, 4'hF, 1'b1);
      prog.delete();
      init_regs(3);  // small values so that equal operands are common
      for (int b = 0; b < 12; b++) begin
         prog.push_back(encode(rand_below(2) ? OP_BNE : OP_BEQ, 1 + rand_below(14),
                               1 + rand_below(14), 0, 4));
         prog.push_back(encode(OP_ADDI, 15, 0, 0, 'h100 + b));  // not taken marker
         prog.push_back(encode(OP_SW, 15, 0, 0, MARK_BASE + b));
         prog.push_back(encode(OP_BEQ, 0, 0, 0, 3));
         prog.push_back(encode(OP_ADDI, 15, 0, 0, 'h200 + b));  // taken marker
         prog.push_back(encode(OP_SW, 15, 0, 0, MARK_BASE + b));
      end
      prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
      load_program();
      interpret();
      run_program(1'b0);
      for (int b = 0; b < 12; b++) begin
         read_and_check("branch marker", MARK_BASE + b, mem_m[WADDR_W'(MARK_BASE + b)]);
      end
   endtask

   task automatic handshake_test();
      prog.delete();
      init_regs(65536);
      prog.push_back(encode(OP_SW, 1, 0, 0, REG_BASE));
      prog.push_back(encode(OP_HALT, 0, 0, 0, 0));
      load_program();
      interpret();
      run_program(1'b1);
      read_and_check("dropped host write", BOOT_BASE, mem_m[BOOT_BASE]);
      read_and_check("store after handshake", REG_BASE, mem_m[REG_BASE]);
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (test_errs != 0) failed++;
      total_errs += test_errs;
      $display("test %0d %s: %s, %0d errors", tests, name, (test_errs == 0) ? "pass" : "FAIL",
               test_errs);
      test_errs = 0;
   endtask

   initial begin
      int waited;
      run_req     = 1'b0;
      host_avalid = 1'b0;
      host_addr   = '0;
      host_wdata  = '0;
      host_wstrb  = '0;
      tests       = 0;
      failed      = 0;
      checks      = 0;
      test_errs   = 0;
      total_errs  = 0;
      for (int k = 0; k < NREGS; k++) rf_m[REG_W'(k)] = '0;
      waited = 0;
      while (!rst_n && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      if (!rst_n) begin
         $display("timeout: reset was never released");
         test_errs++;
      end
      boot_test();
      finish_test("boot and readback");
      alu_test();
      finish_test("alu program");
      memory_test();
      finish_test("memory program");
      branch_test();
      finish_test("branches");
      handshake_test();
      finish_test("handshake and idle rule");
      $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks,
               total_errs);
      if (total_errs == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
src/soc_cfg_pkg.sv
src/isa_pkg.sv
src/iob_bus_if.sv
src/sram.sv
src/host_bridge.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mini_soc.sv
testbench/tb_clock.sv
testbench/mini_soc_assert.sv
testbench/mini_soc_tb.sv

// ==== Makefile ====
# Verilator flow for the mini_soc testbench

VERILATOR ?= verilator
TOP       ?= mini_soc_tb
FILELIST  ?= project.f
SEED_LOG  ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run result is decided by the log, not by the exit status
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@grep -q "All tests passed!" $(SEED_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
